// ==== design/prf_macros.svh ====
//////////////////////////////////////////////////
// rename subsystem sizes
//////////////////////////////////////////////////
`ifndef PRF_MACROS_SVH
`define PRF_MACROS_SVH

// physical register file depth
`define PRF_ENTRIES 64

// RV32I architectural registers
`define ARCH_REGS 32

// common data bus writeback lanes
`define CDB_LANES 2

// index and tag widths
`define PREG_W 6
`define AREG_W 5
`define ROB_ID_W 5

`endif

// ==== design/prf_pkg.sv ====
//////////////////////////////////////////////////
// rename subsystem types
//////////////////////////////////////////////////
`default_nettype none

`include "prf_macros.svh"

package prf_pkg;

    // physical register index
    typedef logic [`PREG_W-1:0] preg_t;

    // architectural register index
    typedef logic [`AREG_W-1:0] areg_t;

    // reorder buffer entry tag
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // data word
    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

// ==== design/free_list.sv ====
//////////////////////////////////////////////////
// free list of physical registers
// circular queue, pop on allocate, push on commit
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "prf_macros.svh"

module free_list (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           alloc,
    input  wire logic           commit,
    input  wire prf_pkg::preg_t commit_preg,
    output prf_pkg::preg_t      alloc_preg,
    output logic                free_empty
);

    // only the registers above the architectural set start out free
    localparam int unsigned DEPTH = `PRF_ENTRIES - `ARCH_REGS;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    prf_pkg::preg_t   fifo [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    // wrap a queue pointer
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            // queue full with 32..63 in order
            for (int i = 0; i < DEPTH; i++) begin
                fifo[i] <= prf_pkg::preg_t'(`ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(DEPTH);
        end else begin
            // pop side
            if (alloc) begin
                head <= ptr_next(head);
            end
            // push side, a released register goes to the back
            if (commit) begin
                fifo[tail] <= commit_preg;
                tail       <= ptr_next(tail);
            end
            // occupancy, unchanged when both happen
            case ({alloc, commit})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head is offered before the pop edge
    assign alloc_preg = fifo[head];
    assign free_empty = (count == '0);

    // dispatcher must hold off while empty
    a_no_alloc_empty: assert property (
        @(posedge clk) disable iff (rst) alloc |-> (count != '0)
    ) else $error("free_list: allocate while empty");

    // more releases than allocations means a double free upstream
    a_no_commit_full: assert property (
        @(posedge clk) disable iff (rst) (commit && !alloc) |-> (count != CNT_W'(DEPTH))
    ) else $error("free_list: release while full");

    // x0 home never enters the queue
    a_no_free_p0: assert property (
        @(posedge clk) disable iff (rst) commit |-> (commit_preg != '0)
    ) else $error("free_list: release of physical 0");

endmodule

`default_nettype wire

// ==== design/rename_table.sv ====
//////////////////////////////////////////////////
// register alias table, arch to physical map
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "prf_macros.svh"

module rename_table (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           dispatch,
    input  wire prf_pkg::areg_t rs1,
    input  wire prf_pkg::areg_t rs2,
    input  wire prf_pkg::areg_t rd,
    input  wire prf_pkg::preg_t alloc_preg,
    output logic                alloc,
    output prf_pkg::preg_t      rs1_preg,
    output prf_pkg::preg_t      rs2_preg,
    output prf_pkg::preg_t      old_preg,
    output prf_pkg::preg_t      rd_preg
);

    // one physical index per architectural register
    prf_pkg::preg_t map [`ARCH_REGS];

    // x0 never gets a new home
    assign alloc = dispatch && (rd != '0);

    // source lookups, combinational
    assign rs1_preg = map[rs1];
    assign rs2_preg = map[rs2];

    // previous mapping of rd, the ROB frees it at commit
    assign old_preg = map[rd];

    // destination tag, physical 0 when nothing is allocated
    assign rd_preg = alloc ? alloc_preg : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= prf_pkg::preg_t'(i);
            end
        end else if (alloc) begin
            // entry 0 is untouched since alloc needs rd nonzero
            map[rd] <= alloc_preg;
        end
    end

    // the free list must never hand out x0's home
    a_alloc_nonzero: assert property (
        @(posedge clk) disable iff (rst) alloc |-> (alloc_preg != '0)
    ) else $error("rename_table: allocated physical 0");

    // a fresh register must not still be mapped by any other entry
    // only checked against the sources read in the same cycle
    a_alloc_not_live: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> (alloc_preg != rs1_preg) && (alloc_preg != rs2_preg)
    ) else $error("rename_table: allocated register still mapped");

endmodule

`default_nettype wire

// ==== design/phys_reg_file.sv ====
//////////////////////////////////////////////////
// physical register file with busy and ROB tags
// CDB writeback, operand reads bypass the CDB
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "prf_macros.svh"

module phys_reg_file (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             alloc,
    input  wire prf_pkg::preg_t   rd_preg,
    input  wire prf_pkg::rob_id_t dispatch_rob_id,
    input  wire prf_pkg::preg_t   rs1_preg,
    input  wire prf_pkg::preg_t   rs2_preg,
    input  wire logic             cdb_valid [`CDB_LANES],
    input  wire prf_pkg::preg_t   cdb_preg [`CDB_LANES],
    input  wire prf_pkg::word_t   cdb_value [`CDB_LANES],
    output prf_pkg::word_t        rs1_value,
    output prf_pkg::word_t        rs2_value,
    output logic                  rs1_ready,
    output logic                  rs2_ready,
    output prf_pkg::rob_id_t      cdb_rob_id [`CDB_LANES]
);

    // per entry storage
    prf_pkg::word_t   value [`PRF_ENTRIES];
    logic             busy [`PRF_ENTRIES];
    prf_pkg::rob_id_t tag [`PRF_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            // all registers zero and ready
            for (int i = 0; i < `PRF_ENTRIES; i++) begin
                value[i] <= '0;
                busy[i]  <= 1'b0;
            end
        end else begin
            // writeback, lanes carry distinct registers
            for (int l = 0; l < `CDB_LANES; l++) begin
                if (cdb_valid[l] && (cdb_preg[l] != '0)) begin
                    value[cdb_preg[l]] <= cdb_value[l];
                    busy[cdb_preg[l]]  <= 1'b0;
                end
            end
            // new destination waits on its producer
            if (alloc && (rd_preg != '0)) begin
                busy[rd_preg] <= 1'b1;
                tag[rd_preg]  <= dispatch_rob_id;
            end
        end
    end

    // stored value unless a lane delivers it this cycle
    function automatic prf_pkg::word_t read_value(input prf_pkg::preg_t p);
        prf_pkg::word_t v;
        v = value[p];
        for (int l = 0; l < `CDB_LANES; l++) begin
            if (cdb_valid[l] && (cdb_preg[l] == p) && (p != '0)) begin
                v = cdb_value[l];
            end
        end
        return v;
    endfunction

    // ready when not busy or arriving on the CDB now
    function automatic logic read_ready(input prf_pkg::preg_t p);
        logic r;
        r = !busy[p];
        for (int l = 0; l < `CDB_LANES; l++) begin
            if (cdb_valid[l] && (cdb_preg[l] == p)) begin
                r = 1'b1;
            end
        end
        return r;
    endfunction

    // operand ports
    always_comb begin
        rs1_value = read_value(rs1_preg);
        rs1_ready = read_ready(rs1_preg);
        rs2_value = read_value(rs2_preg);
        rs2_ready = read_ready(rs2_preg);
    end

    // tag lookup so the ROB can mark completion
    always_comb begin
        for (int l = 0; l < `CDB_LANES; l++) begin
            cdb_rob_id[l] = tag[cdb_preg[l]];
        end
    end

    for (genvar a = 0; a < `CDB_LANES; a++) begin : g_lane_chk
        // a result only returns for a register that was waiting on it
        a_cdb_busy: assert property (
            @(posedge clk) disable iff (rst)
            (cdb_valid[a] && (cdb_preg[a] != '0)) |-> busy[cdb_preg[a]]
        ) else $error("phys_reg_file: CDB lane %0d writes a ready register", a);

        for (genvar b = a + 1; b < `CDB_LANES; b++) begin : g_pair
            // two producers for one register
            a_cdb_distinct: assert property (
                @(posedge clk) disable iff (rst)
                !(cdb_valid[a] && cdb_valid[b] && (cdb_preg[a] == cdb_preg[b]))
            ) else $error("phys_reg_file: CDB lanes %0d and %0d collide", a, b);
        end
    end

endmodule

`default_nettype wire

// ==== design/rename_top.sv ====
//////////////////////////////////////////////////
// rename and physical register file top level
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "prf_macros.svh"

module rename_top (
    input  wire logic             clk,
    input  wire logic             rst,
    // dispatch lane
    input  wire logic             dispatch,
    input  wire prf_pkg::areg_t   rs1,
    input  wire prf_pkg::areg_t   rs2,
    input  wire prf_pkg::areg_t   rd,
    input  wire prf_pkg::rob_id_t dispatch_rob_id,
    // writeback lanes
    input  wire logic             cdb_valid [`CDB_LANES],
    input  wire prf_pkg::preg_t   cdb_preg [`CDB_LANES],
    input  wire prf_pkg::word_t   cdb_value [`CDB_LANES],
    // commit
    input  wire logic             commit,
    input  wire prf_pkg::preg_t   commit_preg,
    // renamed instruction
    output prf_pkg::preg_t        rs1_preg,
    output prf_pkg::preg_t        rs2_preg,
    output prf_pkg::preg_t        rd_preg,
    output prf_pkg::preg_t        old_preg,
    // operands
    output prf_pkg::word_t        rs1_value,
    output logic                  rs1_ready,
    output prf_pkg::word_t        rs2_value,
    output logic                  rs2_ready,
    output prf_pkg::rob_id_t      cdb_rob_id [`CDB_LANES],
    output logic                  free_empty
);

    logic           alloc;
    prf_pkg::preg_t alloc_preg;

    free_list u_free_list (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .commit      (commit),
        .commit_preg (commit_preg),
        .alloc_preg  (alloc_preg),
        .free_empty  (free_empty)
    );

    rename_table u_rename_table (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .alloc_preg (alloc_preg),
        .alloc      (alloc),
        .rs1_preg   (rs1_preg),
        .rs2_preg   (rs2_preg),
        .old_preg   (old_preg),
        .rd_preg    (rd_preg)
    );

    // sources read through the freshly renamed indices
    phys_reg_file u_phys_reg_file (
        .clk             (clk),
        .rst             (rst),
        .alloc           (alloc),
        .rd_preg         (rd_preg),
        .dispatch_rob_id (dispatch_rob_id),
        .rs1_preg        (rs1_preg),
        .rs2_preg        (rs2_preg),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .cdb_value       (cdb_value),
        .rs1_value       (rs1_value),
        .rs2_value       (rs2_value),
        .rs1_ready       (rs1_ready),
        .rs2_ready       (rs2_ready),
        .cdb_rob_id      (cdb_rob_id)
    );

endmodule

`default_nettype wire

// ==== sim/rename_checker.sv ====
//////////////////////////////////////////////////
// rename checker, compares DUT ports each cycle
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "prf_macros.svh"

module rename_checker (
    input  wire logic             clk,
    input  wire logic             check_en,
    input  wire logic [15:0]      row,
    // expected values for the current row
    input  wire prf_pkg::preg_t   exp_rs1_preg,
    input  wire prf_pkg::preg_t   exp_rs2_preg,
    input  wire prf_pkg::preg_t   exp_rd_preg,
    input  wire prf_pkg::preg_t   exp_old_preg,
    input  wire prf_pkg::word_t   exp_rs1_value,
    input  wire logic             exp_rs1_ready,
    input  wire prf_pkg::word_t   exp_rs2_value,
    input  wire logic             exp_rs2_ready,
    input  wire prf_pkg::rob_id_t exp_cdb_rob_id [`CDB_LANES],
    input  wire logic             exp_free_empty,
    // watched DUT ports
    input  wire logic             cdb_valid [`CDB_LANES],
    input  wire prf_pkg::preg_t   rs1_preg,
    input  wire prf_pkg::preg_t   rs2_preg,
    input  wire prf_pkg::preg_t   rd_preg,
    input  wire prf_pkg::preg_t   old_preg,
    input  wire prf_pkg::word_t   rs1_value,
    input  wire logic             rs1_ready,
    input  wire prf_pkg::word_t   rs2_value,
    input  wire logic             rs2_ready,
    input  wire prf_pkg::rob_id_t cdb_rob_id [`CDB_LANES],
    input  wire logic             free_empty,
    output int                    error_count,
    output int                    check_count
);

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // one mismatch line per wrong signal
    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns row %0d %s expected %h got %h",
                     $time, row, name, expected, actual);
            error_count++;
        end
    endtask

    // outputs settle after the falling edge drive, read them before the state update
    always @(posedge clk) begin
        if (check_en) begin
            check_count++;
            compare("rs1_preg", exp_rs1_preg, rs1_preg);
            compare("rs2_preg", exp_rs2_preg, rs2_preg);
            compare("rd_preg", exp_rd_preg, rd_preg);
            compare("old_preg", exp_old_preg, old_preg);
            compare("rs1_value", exp_rs1_value, rs1_value);
            compare("rs1_ready", exp_rs1_ready, rs1_ready);
            compare("rs2_value", exp_rs2_value, rs2_value);
            compare("rs2_ready", exp_rs2_ready, rs2_ready);
            compare("free_empty", exp_free_empty, free_empty);
            for (int l = 0; l < `CDB_LANES; l++) begin
                // a tag only means something on a lane that carries a result
                if (cdb_valid[l]) begin
                    compare($sformatf("cdb_rob_id[%0d]", l), exp_cdb_rob_id[l], cdb_rob_id[l]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/rename_tb.sv ====
//////////////////////////////////////////////////
// testbench for the rename and register file top
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "prf_macros.svh"

module rename_tb;

    localparam int MAX_ROWS     = 64;
    localparam int RESET_CYCLES = 4;
    localparam int LANES        = `CDB_LANES;

    // DUT inputs
    logic             clk = 1'b0;
    logic             rst;
    logic             dispatch;
    prf_pkg::areg_t   rs1;
    prf_pkg::areg_t   rs2;
    prf_pkg::areg_t   rd;
    prf_pkg::rob_id_t dispatch_rob_id;
    logic             cdb_valid [LANES];
    prf_pkg::preg_t   cdb_preg [LANES];
    prf_pkg::word_t   cdb_value [LANES];
    logic             commit;
    prf_pkg::preg_t   commit_preg;

    // DUT outputs
    prf_pkg::preg_t   rs1_preg;
    prf_pkg::preg_t   rs2_preg;
    prf_pkg::preg_t   rd_preg;
    prf_pkg::preg_t   old_preg;
    prf_pkg::word_t   rs1_value;
    logic             rs1_ready;
    prf_pkg::word_t   rs2_value;
    logic             rs2_ready;
    prf_pkg::rob_id_t cdb_rob_id [LANES];
    logic             free_empty;

    // expectations handed to the checker with each row
    logic             check_en;
    logic [15:0]      row_idx;
    prf_pkg::preg_t   exp_rs1_preg;
    prf_pkg::preg_t   exp_rs2_preg;
    prf_pkg::preg_t   exp_rd_preg;
    prf_pkg::preg_t   exp_old_preg;
    prf_pkg::word_t   exp_rs1_value;
    logic             exp_rs1_ready;
    prf_pkg::word_t   exp_rs2_value;
    logic             exp_rs2_ready;
    prf_pkg::rob_id_t exp_cdb_rob_id [LANES];
    logic             exp_free_empty;
    int               error_count;
    int               check_count;

    // stimulus columns
    logic             t_dispatch [MAX_ROWS];
    prf_pkg::areg_t   t_rs1 [MAX_ROWS];
    prf_pkg::areg_t   t_rs2 [MAX_ROWS];
    prf_pkg::areg_t   t_rd [MAX_ROWS];
    prf_pkg::rob_id_t t_rob_id [MAX_ROWS];
    logic             t_cdb_valid [MAX_ROWS][LANES];
    prf_pkg::preg_t   t_cdb_preg [MAX_ROWS][LANES];
    prf_pkg::word_t   t_cdb_value [MAX_ROWS][LANES];
    logic             t_commit [MAX_ROWS];
    prf_pkg::preg_t   t_commit_preg [MAX_ROWS];
    // expected columns
    prf_pkg::preg_t   t_rs1_preg [MAX_ROWS];
    prf_pkg::preg_t   t_rs2_preg [MAX_ROWS];
    prf_pkg::preg_t   t_rd_preg [MAX_ROWS];
    prf_pkg::preg_t   t_old_preg [MAX_ROWS];
    prf_pkg::word_t   t_rs1_value [MAX_ROWS];
    logic             t_rs1_ready [MAX_ROWS];
    prf_pkg::word_t   t_rs2_value [MAX_ROWS];
    logic             t_rs2_ready [MAX_ROWS];
    prf_pkg::rob_id_t t_cdb_rob_id [MAX_ROWS][LANES];
    logic             t_free_empty [MAX_ROWS];

    // reference state used while the table is filled
    prf_pkg::preg_t   m_map [`ARCH_REGS];
    prf_pkg::preg_t   m_free [$];
    prf_pkg::word_t   m_value [`PRF_ENTRIES];
    logic             m_busy [`PRF_ENTRIES];
    prf_pkg::rob_id_t m_tag [`PRF_ENTRIES];

    int               n_rows = 0;
    int               cycles = 0;
    int               timeout_limit = 1000;
    logic [31:0]      lcg_state = 32'hae81_dd86;

    rename_top UUT (
        .clk(clk), .rst(rst), .dispatch(dispatch), .rs1(rs1), .rs2(rs2), .rd(rd),
        .dispatch_rob_id(dispatch_rob_id), .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .cdb_value(cdb_value), .commit(commit), .commit_preg(commit_preg),
        .rs1_preg(rs1_preg), .rs2_preg(rs2_preg), .rd_preg(rd_preg), .old_preg(old_preg),
        .rs1_value(rs1_value), .rs1_ready(rs1_ready), .rs2_value(rs2_value),
        .rs2_ready(rs2_ready), .cdb_rob_id(cdb_rob_id), .free_empty(free_empty)
    );

    rename_checker u_checker (
        .clk(clk), .check_en(check_en), .row(row_idx),
        .exp_rs1_preg(exp_rs1_preg), .exp_rs2_preg(exp_rs2_preg),
        .exp_rd_preg(exp_rd_preg), .exp_old_preg(exp_old_preg),
        .exp_rs1_value(exp_rs1_value), .exp_rs1_ready(exp_rs1_ready),
        .exp_rs2_value(exp_rs2_value), .exp_rs2_ready(exp_rs2_ready),
        .exp_cdb_rob_id(exp_cdb_rob_id), .exp_free_empty(exp_free_empty),
        .cdb_valid(cdb_valid), .rs1_preg(rs1_preg), .rs2_preg(rs2_preg),
        .rd_preg(rd_preg), .old_preg(old_preg), .rs1_value(rs1_value),
        .rs1_ready(rs1_ready), .rs2_value(rs2_value), .rs2_ready(rs2_ready),
        .cdb_rob_id(cdb_rob_id), .free_empty(free_empty),
        .error_count(error_count), .check_count(check_count)
    );

    always #10 clk = ~clk;

    // runaway guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_limit) begin
            $display("run did not finish within %0d cycles, stopping", timeout_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // CDB payloads
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // {ready, value} an operand read of p should give in row r
    function automatic logic [32:0] operand(input int r, input prf_pkg::preg_t p);
        logic [32:0] res;
        res = {!m_busy[p], m_value[p]};
        for (int l = 0; l < LANES; l++) begin
            if (t_cdb_valid[r][l] && (t_cdb_preg[r][l] == p)) begin
                res = {1'b1, t_cdb_value[r][l]};
            end
        end
        // x0 home is hard wired
        if (p == '0) begin
            res = {1'b1, 32'h0};
        end
        return res;
    endfunction

    task automatic new_row();
        t_dispatch[n_rows] = 1'b0;
        t_rs1[n_rows] = '0;
        t_rs2[n_rows] = '0;
        t_rd[n_rows] = '0;
        t_rob_id[n_rows] = prf_pkg::rob_id_t'(n_rows);
        for (int l = 0; l < LANES; l++) begin
            t_cdb_valid[n_rows][l] = 1'b0;
            t_cdb_preg[n_rows][l] = '0;
            t_cdb_value[n_rows][l] = '0;
        end
        t_commit[n_rows] = 1'b0;
        t_commit_preg[n_rows] = '0;
    endtask

    task automatic dispatch_op(input int src1, input int src2, input int dst);
        t_dispatch[n_rows] = 1'b1;
        t_rs1[n_rows] = prf_pkg::areg_t'(src1);
        t_rs2[n_rows] = prf_pkg::areg_t'(src2);
        t_rd[n_rows] = prf_pkg::areg_t'(dst);
    endtask

    task automatic cdb_op(input int lane, input int preg);
        t_cdb_valid[n_rows][lane] = 1'b1;
        t_cdb_preg[n_rows][lane] = prf_pkg::preg_t'(preg);
        t_cdb_value[n_rows][lane] = next_random();
    endtask

    task automatic commit_op(input int preg);
        t_commit[n_rows] = 1'b1;
        t_commit_preg[n_rows] = prf_pkg::preg_t'(preg);
    endtask

    // fill in the expectations, then step the reference state over the edge
    task automatic close_row();
        int             r;
        logic           alloc;
        logic [32:0]    op;
        prf_pkg::preg_t fresh;
        r = n_rows;
        alloc = t_dispatch[r] && (t_rd[r] != '0);
        fresh = (m_free.size() > 0) ? m_free[0] : '0;
        t_rs1_preg[r] = m_map[t_rs1[r]];
        t_rs2_preg[r] = m_map[t_rs2[r]];
        t_old_preg[r] = m_map[t_rd[r]];
        t_rd_preg[r] = alloc ? fresh : '0;
        op = operand(r, t_rs1_preg[r]);
        t_rs1_value[r] = op[31:0];
        t_rs1_ready[r] = op[32];
        op = operand(r, t_rs2_preg[r]);
        t_rs2_value[r] = op[31:0];
        t_rs2_ready[r] = op[32];
        t_free_empty[r] = (m_free.size() == 0);
        for (int l = 0; l < LANES; l++) begin
            t_cdb_rob_id[r][l] = m_tag[t_cdb_preg[r][l]];
            if (t_cdb_valid[r][l] && (t_cdb_preg[r][l] != '0)) begin
                m_value[t_cdb_preg[r][l]] = t_cdb_value[r][l];
                m_busy[t_cdb_preg[r][l]] = 1'b0;
            end
        end
        if (alloc) begin
            m_busy[fresh] = 1'b1;
            m_tag[fresh] = t_rob_id[r];
            m_map[t_rd[r]] = fresh;
            void'(m_free.pop_front());
        end
        if (t_commit[r]) begin
            m_free.push_back(t_commit_preg[r]);
        end
        n_rows++;
    endtask

    // a row with a dispatch only
    task automatic dispatch_row(input int src1, input int src2, input int dst);
        new_row();
        dispatch_op(src1, src2, dst);
        close_row();
    endtask

    // a row with a commit only
    task automatic commit_row(input int preg);
        new_row();
        commit_op(preg);
        close_row();
    endtask

    // a row with every strobe low
    task automatic idle_row();
        new_row();
        close_row();
    endtask

    task automatic build_table();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            m_map[i] = prf_pkg::preg_t'(i);
        end
        for (int i = 0; i < `PRF_ENTRIES; i++) begin
            m_value[i] = '0;
            m_busy[i] = 1'b0;
            m_tag[i] = '0;
        end
        for (int i = `ARCH_REGS; i < `PRF_ENTRIES; i++) begin
            m_free.push_back(prf_pkg::preg_t'(i));
        end
        // identity map straight after reset
        dispatch_row(5, 7, 0);
        idle_row();
        // allocation order 32, 33, 34 with a pending source
        dispatch_row(2, 3, 1);
        dispatch_row(1, 1, 2);
        dispatch_row(2, 1, 3);
        // x1 result arrives and is bypassed, then read from storage
        new_row();
        dispatch_op(1, 2, 4);
        cdb_op(0, 32);
        close_row();
        dispatch_row(1, 4, 0);
        // x0 destination and sources, idle lane parked on physical 0
        new_row();
        dispatch_op(0, 0, 0);
        t_cdb_value[n_rows][1] = next_random();
        close_row();
        // drain the free list, each source is the previous destination
        for (int i = 0; i < 28; i++) begin
            dispatch_row(4 + i % 26, 1, 5 + i % 26);
        end
        idle_row();
        // recycling follows release order
        commit_row(1);
        dispatch_row(7, 8, 9);
        commit_row(2);
        commit_row(3);
        new_row();
        dispatch_op(9, 0, 10);
        commit_op(4);
        close_row();
        dispatch_row(10, 9, 11);
        // both lanes at once
        new_row();
        dispatch_op(5, 6, 0);
        cdb_op(0, m_map[5]);
        cdb_op(1, m_map[6]);
        close_row();
        dispatch_row(5, 6, 0);
        new_row();
        dispatch_op(9, 10, 12);
        cdb_op(1, m_map[9]);
        close_row();
        dispatch_row(9, 12, 0);
    endtask

    task automatic drive_row(input int r);
        dispatch = t_dispatch[r];
        rs1 = t_rs1[r];
        rs2 = t_rs2[r];
        rd = t_rd[r];
        dispatch_rob_id = t_rob_id[r];
        for (int l = 0; l < LANES; l++) begin
            cdb_valid[l] = t_cdb_valid[r][l];
            cdb_preg[l] = t_cdb_preg[r][l];
            cdb_value[l] = t_cdb_value[r][l];
            exp_cdb_rob_id[l] = t_cdb_rob_id[r][l];
        end
        commit = t_commit[r];
        commit_preg = t_commit_preg[r];
        exp_rs1_preg = t_rs1_preg[r];
        exp_rs2_preg = t_rs2_preg[r];
        exp_rd_preg = t_rd_preg[r];
        exp_old_preg = t_old_preg[r];
        exp_rs1_value = t_rs1_value[r];
        exp_rs1_ready = t_rs1_ready[r];
        exp_rs2_value = t_rs2_value[r];
        exp_rs2_ready = t_rs2_ready[r];
        exp_free_empty = t_free_empty[r];
        row_idx = 16'(r);
        check_en = 1'b1;
    endtask

    initial begin
        rst = 1'b1;
        check_en = 1'b0;
        row_idx = '0;
        build_table();
        timeout_limit = n_rows + RESET_CYCLES + 20;
        // all inputs quiet during reset
        new_row();
        drive_row(n_rows);
        check_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            drive_row(r);
            @(negedge clk);
        end
        check_en = 1'b0;
        dispatch = 1'b0;
        commit = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            cdb_valid[l] = 1'b0;
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, check_count, error_count);
        if (check_count != n_rows) begin
            $display("checker saw %0d rows but %0d were driven", check_count, n_rows);
        end
        if ((error_count == 0) && (check_count == n_rows)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/prf_pkg.sv
design/free_list.sv
design/rename_table.sv
design/phys_reg_file.sv
design/rename_top.sv
sim/rename_checker.sv
sim/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_prf

sources:
  - include_dirs:
      - design
    files:
      - design/prf_pkg.sv
      - design/free_list.sv
      - design/rename_table.sv
      - design/phys_reg_file.sv
      - design/rename_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/rename_checker.sv
      - sim/rename_tb.sv
